/* src/brick_defines.svh */
`ifndef BRICK_DEFINES_SVH
`define BRICK_DEFINES_SVH

// frame buffer size
`define SCREEN_W 160
`define SCREEN_H 120

// brick geometry and grid
`define BRICK_W 16
`define BRICK_H 4
`define BRICK_COLS 10
`define BRICK_ROWS 4
`define BRICK_COUNT (`BRICK_COLS * `BRICK_ROWS)
`define BRICK_PITCH_Y 8 // rows from one brick row to the next

// paddle
`define PADDLE_W 16
`define PADDLE_H 4
`define PADDLE_Y 115
`define PADDLE_RESET_X 80

// ball, square
`define BALL_SIZE 2
`define BALL_RESET_X 88
`define BALL_RESET_Y 98
`define BALL_PADDLE_Y 110 // ball row where the paddle is tested
`define BALL_FLOOR_Y 117

// frames per update
`define PADDLE_FRAMES 3
`define BALL_FRAMES 2

`endif

/* src/video_pkg.sv */
package video_pkg;

	// screen coordinates, 160x120
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;

	// 3-bit rgb
	typedef logic [2:0] colour_t;

	localparam colour_t COLOUR_BLACK = 3'd0;
	localparam colour_t COLOUR_RED = 3'd4;
	localparam colour_t COLOUR_WHITE = 3'd7;

	// one word of the brick table
	// a black brick has already been hit
	typedef struct packed {
		colour_t colour;
		coord_y_t y;
		coord_x_t x;
	} brick_rec_t;

endpackage

/* src/game_pkg.sv */
package game_pkg;

	// what the engine is doing; one pixel or one table access per cycle
	typedef enum logic [3:0] {
		CLEAR, // whole screen to black
		FILL, // load brick table
		DRAW_BRICKS,
		DRAW_PADDLE,
		IDLE, // wait for a due update
		ERASE_PADDLE,
		MOVE_PADDLE,
		ERASE_BALL,
		SCAN, // walk the table for a collision
		MARK_HIT, // blacken the hit brick in the table
		ERASE_BRICK,
		MOVE_BALL,
		DRAW_BALL
	} game_phase_t;

endpackage

/* src/game_sequencer.sv */
`timescale 1ns/1ps
`include "brick_defines.svh"

module game_sequencer #(
	parameter int frame_ticks = 833333
) (
	input logic clk,
	input logic resetn,
	input logic hit_valid,
	output game_pkg::game_phase_t phase,
	output logic [11:0] step
);
	import game_pkg::*;

	localparam int TIMER_W = $clog2(frame_ticks);

	logic [14:0] count; // wider than step, the clear raster needs it
	logic [14:0] last_step;
	logic phase_done;
	game_phase_t next_phase;
	logic serve_paddle;
	logic serve_ball;

	logic [TIMER_W-1:0] timer;
	logic frame_tick;
	logic [1:0] paddle_frames;
	logic [1:0] ball_frames;
	logic paddle_wrap;
	logic ball_wrap;
	logic paddle_due;
	logic ball_due;

	assign step = count[11:0];

	// last step of each phase
	always_comb
	begin
		case (phase)
			CLEAR: last_step = 15'(`SCREEN_W * `SCREEN_H); // +1, painter arms on step 0
			FILL: last_step = 15'(`BRICK_COUNT - 1);
			DRAW_BRICKS: last_step = 15'(`BRICK_COUNT * `BRICK_W * `BRICK_H - 1);
			DRAW_PADDLE, ERASE_PADDLE: last_step = 15'(`PADDLE_W * `PADDLE_H - 1);
			ERASE_BRICK: last_step = 15'(`BRICK_W * `BRICK_H - 1);
			ERASE_BALL, DRAW_BALL: last_step = 15'(`BALL_SIZE * `BALL_SIZE - 1);
			SCAN: last_step = 15'(`BRICK_COUNT); // one extra for the read latency
			default: last_step = '0; // single cycle phases
		endcase
	end

	assign phase_done = (count == last_step);

	always_comb
	begin
		next_phase = phase;
		serve_paddle = 1'b0;
		serve_ball = 1'b0;
		case (phase)
			CLEAR: if (phase_done) next_phase = FILL;
			FILL: if (phase_done) next_phase = DRAW_BRICKS;
			DRAW_BRICKS: if (phase_done) next_phase = DRAW_PADDLE;
			DRAW_PADDLE: if (phase_done) next_phase = IDLE;
			IDLE:
			begin
				// paddle wins when both are due
				if (paddle_due)
				begin
					next_phase = ERASE_PADDLE;
					serve_paddle = 1'b1;
				end
				else if (ball_due)
				begin
					next_phase = ERASE_BALL;
					serve_ball = 1'b1;
				end
			end
			ERASE_PADDLE: if (phase_done) next_phase = MOVE_PADDLE;
			MOVE_PADDLE: next_phase = DRAW_PADDLE;
			ERASE_BALL: if (phase_done) next_phase = SCAN;
			SCAN: if (phase_done) next_phase = MARK_HIT;
			MARK_HIT: next_phase = hit_valid ? ERASE_BRICK : MOVE_BALL; // nothing to erase on a miss
			ERASE_BRICK: if (phase_done) next_phase = MOVE_BALL;
			MOVE_BALL: next_phase = DRAW_BALL;
			DRAW_BALL: if (phase_done) next_phase = IDLE;
			default: next_phase = CLEAR;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			phase <= CLEAR;
			count <= '0;
		end
		else if (next_phase != phase)
		begin
			phase <= next_phase;
			count <= '0;
		end
		else
			count <= count + 15'd1;
	end

	// frame pacing
	assign frame_tick = (timer == TIMER_W'(frame_ticks - 1));
	assign paddle_wrap = frame_tick && (paddle_frames == 2'(`PADDLE_FRAMES - 1));
	assign ball_wrap = frame_tick && (ball_frames == 2'(`BALL_FRAMES - 1));

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			timer <= '0;
			paddle_frames <= '0;
			ball_frames <= '0;
			paddle_due <= 1'b0;
			ball_due <= 1'b0;
		end
		else
		begin
			timer <= frame_tick ? '0 : timer + 1'b1;
			if (frame_tick)
			begin
				paddle_frames <= paddle_wrap ? 2'd0 : paddle_frames + 2'd1;
				ball_frames <= ball_wrap ? 2'd0 : ball_frames + 2'd1;
			end
			// a new due beats a serve in the same cycle
			if (paddle_wrap)
				paddle_due <= 1'b1;
			else if (serve_paddle)
				paddle_due <= 1'b0;
			if (ball_wrap)
				ball_due <= 1'b1;
			else if (serve_ball)
				ball_due <= 1'b0;
		end
	end

endmodule

/* src/brick_table.sv */
`timescale 1ns/1ps
`include "brick_defines.svh"

module brick_table (
	input logic clk,
	input logic resetn,
	input game_pkg::game_phase_t phase,
	input logic [11:0] step,
	input logic hit_valid,
	input logic [5:0] hit_index,
	output video_pkg::brick_rec_t rd_brick,
	output logic [5:0] rd_index
);
	import game_pkg::*;
	import video_pkg::*;

	brick_rec_t bricks [`BRICK_COUNT];

	logic [5:0] fill_idx;
	brick_rec_t fill_rec;
	logic [5:0] rd_addr;

	assign fill_idx = step[5:0];

	// grid layout, colours cycle 1..7
	always_comb
	begin
		fill_rec.colour = colour_t'(3'd1 + 3'(fill_idx % 7));
		fill_rec.y = coord_y_t'((fill_idx / `BRICK_COLS) * `BRICK_PITCH_Y);
		fill_rec.x = coord_x_t'((fill_idx % `BRICK_COLS) * `BRICK_W);
	end

	always_ff @(posedge clk)
	begin
		if (phase == FILL)
			bricks[fill_idx] <= fill_rec;
		else if (phase == MARK_HIT && hit_valid)
			bricks[hit_index].colour <= COLOUR_BLACK; // position stays
	end

	always_comb
	begin
		case (phase)
			// fetch one step ahead so the pixel lines up with its step
			DRAW_BRICKS: rd_addr = 6'((step + 12'd1) / (`BRICK_W * `BRICK_H));
			SCAN: rd_addr = step[5:0];
			default: rd_addr = '0; // end of FILL leaves brick 0 loaded
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			rd_brick <= '0;
			rd_index <= '0;
		end
		else
		begin
			rd_index <= rd_addr;
			if (rd_addr < 6'(`BRICK_COUNT))
				rd_brick <= bricks[rd_addr];
		end
	end

endmodule

/* src/motion_unit.sv */
`timescale 1ns/1ps
`include "brick_defines.svh"

module motion_unit (
	input logic clk,
	input logic resetn,
	input game_pkg::game_phase_t phase,
	input logic [11:0] step,
	input video_pkg::coord_x_t paddle_target,
	input video_pkg::brick_rec_t rd_brick,
	input logic [5:0] rd_index,
	output video_pkg::coord_x_t paddle_x,
	output video_pkg::coord_x_t ball_x,
	output video_pkg::coord_y_t ball_y,
	output logic hit_valid,
	output logic [5:0] hit_index,
	output video_pkg::coord_x_t hit_origin_x,
	output video_pkg::coord_y_t hit_origin_y
);
	import game_pkg::*;
	import video_pkg::*;

	logic dir_right;
	logic dir_down;

	logic scan_test;
	logic in_cols;
	logic in_rows;
	logic hit_top;
	logic hit_bottom;
	logic hit_left;
	logic hit_right;
	logic capture;
	logic on_paddle;

	// only the first live brick in the scan counts
	assign scan_test = (phase == SCAN) && (step != 12'd0) && (step <= 12'(`BRICK_COUNT))
		&& !hit_valid && (rd_brick.colour != COLOUR_BLACK);

	assign in_cols = (ball_x >= rd_brick.x)
		&& ({1'b0, ball_x} <= {1'b0, rd_brick.x} + 9'(`BRICK_W - 1));
	assign in_rows = (ball_y >= rd_brick.y)
		&& ({1'b0, ball_y} <= {1'b0, rd_brick.y} + 8'(`BRICK_H - 1));

	assign hit_top = in_cols && ({1'b0, ball_y} + 8'd1 == {1'b0, rd_brick.y});
	assign hit_bottom = in_cols && ({1'b0, ball_y} == {1'b0, rd_brick.y} + 8'(`BRICK_H));
	assign hit_left = in_rows && ({1'b0, ball_x} + 9'd1 == {1'b0, rd_brick.x});
	assign hit_right = in_rows && ({1'b0, ball_x} == {1'b0, rd_brick.x} + 9'(`BRICK_W));

	assign capture = scan_test && (hit_top || hit_bottom || hit_left || hit_right);

	assign on_paddle = (ball_x >= paddle_x)
		&& ({1'b0, ball_x} <= {1'b0, paddle_x} + 9'(`PADDLE_W - 1));

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			paddle_x <= coord_x_t'(`PADDLE_RESET_X);
			ball_x <= coord_x_t'(`BALL_RESET_X);
			ball_y <= coord_y_t'(`BALL_RESET_Y);
			dir_right <= 1'b1;
			dir_down <= 1'b0;
			hit_valid <= 1'b0;
		end
		else
		begin
			case (phase)
				MOVE_PADDLE: paddle_x <= paddle_target;
				SCAN:
				begin
					if (capture)
					begin
						hit_valid <= 1'b1;
						if (hit_top)
							dir_down <= 1'b0;
						else if (hit_bottom)
							dir_down <= 1'b1;
						else if (hit_left)
							dir_right <= 1'b0;
						else
							dir_right <= 1'b1;
					end
				end
				MOVE_BALL:
				begin
					hit_valid <= 1'b0;
					if (dir_right)
					begin
						if (ball_x == coord_x_t'(`SCREEN_W - `BALL_SIZE))
						begin
							ball_x <= coord_x_t'(`SCREEN_W - `BALL_SIZE - 1);
							dir_right <= 1'b0;
						end
						else
							ball_x <= ball_x + 8'd1;
					end
					else if (ball_x == '0)
					begin
						ball_x <= 8'd1;
						dir_right <= 1'b1;
					end
					else
						ball_x <= ball_x - 8'd1;

					if (dir_down)
					begin
						if (ball_y == coord_y_t'(`BALL_PADDLE_Y) && on_paddle)
						begin
							ball_y <= coord_y_t'(`BALL_PADDLE_Y - 1);
							dir_down <= 1'b0;
						end
						else if (ball_y == coord_y_t'(`BALL_FLOOR_Y))
						begin
							ball_y <= coord_y_t'(`BALL_FLOOR_Y - 1); // floor bounces too
							dir_down <= 1'b0;
						end
						else
							ball_y <= ball_y + 7'd1;
					end
					else if (ball_y == '0)
					begin
						ball_y <= 7'd1;
						dir_down <= 1'b1;
					end
					else
						ball_y <= ball_y - 7'd1;
				end
				default: ;
			endcase
		end
	end

	// which brick, for the table and the eraser
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			hit_index <= rd_index;
			hit_origin_x <= rd_brick.x;
			hit_origin_y <= rd_brick.y;
		end
	end

endmodule

/* src/pixel_painter.sv */
`timescale 1ns/1ps
`include "brick_defines.svh"

module pixel_painter (
	input logic clk,
	input logic resetn,
	input game_pkg::game_phase_t phase,
	input logic [11:0] step,
	input video_pkg::brick_rec_t rd_brick,
	input video_pkg::coord_x_t paddle_x,
	input video_pkg::coord_x_t ball_x,
	input video_pkg::coord_x_t hit_origin_x,
	input video_pkg::coord_y_t ball_y,
	input video_pkg::coord_y_t hit_origin_y,
	output logic plot,
	output video_pkg::coord_x_t x,
	output video_pkg::coord_y_t y,
	output video_pkg::colour_t colour
);
	import game_pkg::*;
	import video_pkg::*;

	logic active; // low for the release cycle
	coord_x_t clear_x;
	coord_y_t clear_y;
	logic [3:0] col_off;
	logic [1:0] row_off;

	// 16 columns by 4 rows per 64 steps
	assign col_off = step[3:0];
	assign row_off = step[5:4];

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			active <= 1'b0;
			clear_x <= '0;
			clear_y <= '0;
		end
		else
		begin
			active <= 1'b1;
			if (active && phase == CLEAR)
			begin
				if (clear_x == coord_x_t'(`SCREEN_W - 1))
				begin
					clear_x <= '0;
					clear_y <= (clear_y == coord_y_t'(`SCREEN_H - 1)) ? '0 : clear_y + 7'd1;
				end
				else
					clear_x <= clear_x + 8'd1;
			end
		end
	end

	always_comb
	begin
		plot = 1'b0;
		x = clear_x;
		y = clear_y;
		colour = COLOUR_BLACK;
		case (phase)
			CLEAR: plot = active;
			DRAW_BRICKS:
			begin
				plot = 1'b1;
				x = rd_brick.x + coord_x_t'(col_off);
				y = rd_brick.y + coord_y_t'(row_off);
				colour = rd_brick.colour;
			end
			ERASE_PADDLE, DRAW_PADDLE:
			begin
				plot = 1'b1;
				x = paddle_x + coord_x_t'(col_off);
				y = coord_y_t'(`PADDLE_Y) + coord_y_t'(row_off);
				colour = (phase == DRAW_PADDLE) ? COLOUR_WHITE : COLOUR_BLACK;
			end
			ERASE_BALL, DRAW_BALL:
			begin
				plot = 1'b1;
				x = ball_x + coord_x_t'(step[0]); // 2x2 block
				y = ball_y + coord_y_t'(step[1]);
				colour = (phase == DRAW_BALL) ? COLOUR_RED : COLOUR_BLACK;
			end
			ERASE_BRICK:
			begin
				plot = 1'b1;
				x = hit_origin_x + coord_x_t'(col_off);
				y = hit_origin_y + coord_y_t'(row_off);
			end
			default: ;
		endcase
	end

endmodule

/* src/brick_breaker_top.sv */
`timescale 1ns/1ps

module brick_breaker_top #(
	parameter int frame_ticks = 833333
) (
	input logic clk,
	input logic resetn,
	input video_pkg::coord_x_t paddle_target,
	output logic plot,
	output video_pkg::coord_x_t x,
	output video_pkg::coord_y_t y,
	output video_pkg::colour_t colour
);
	import game_pkg::*;
	import video_pkg::*;

	game_phase_t phase;
	logic [11:0] step;
	brick_rec_t rd_brick;
	logic [5:0] rd_index;
	logic hit_valid;
	logic [5:0] hit_index;
	coord_x_t paddle_x;
	coord_x_t ball_x;
	coord_y_t ball_y;
	coord_x_t hit_origin_x;
	coord_y_t hit_origin_y;

	game_sequencer #(
		.frame_ticks(frame_ticks)
	) u_sequencer (
		.clk(clk),
		.resetn(resetn),
		.hit_valid(hit_valid),
		.phase(phase),
		.step(step)
	);

	brick_table u_table (
		.clk(clk),
		.resetn(resetn),
		.phase(phase),
		.step(step),
		.hit_valid(hit_valid),
		.hit_index(hit_index),
		.rd_brick(rd_brick),
		.rd_index(rd_index)
	);

	motion_unit u_motion (
		.clk(clk),
		.resetn(resetn),
		.phase(phase),
		.step(step),
		.paddle_target(paddle_target),
		.rd_brick(rd_brick),
		.rd_index(rd_index),
		.paddle_x(paddle_x),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.hit_valid(hit_valid),
		.hit_index(hit_index),
		.hit_origin_x(hit_origin_x),
		.hit_origin_y(hit_origin_y)
	);

	pixel_painter u_painter (
		.clk(clk),
		.resetn(resetn),
		.phase(phase),
		.step(step),
		.rd_brick(rd_brick),
		.paddle_x(paddle_x),
		.ball_x(ball_x),
		.hit_origin_x(hit_origin_x),
		.ball_y(ball_y),
		.hit_origin_y(hit_origin_y),
		.plot(plot),
		.x(x),
		.y(y),
		.colour(colour)
	);

endmodule

/* dv/tb_brick_breaker.sv */
`timescale 1ns/1ps
`include "brick_defines.svh"

module tb_brick_breaker;

	localparam int FRAME_TICKS = 4000;
	localparam int TEST_FRAMES = 40;
	localparam int TIMEOUT_CYCLES = 19200 + 2600 + TEST_FRAMES * FRAME_TICKS + 20000;
	localparam int CLEAR_PIXELS = `SCREEN_W * `SCREEN_H;
	localparam int BLOCK_PIXELS = `BRICK_W * `BRICK_H; // brick and paddle are both 16x4
	localparam int BALL_PIXELS = `BALL_SIZE * `BALL_SIZE;
	localparam int STIM_COUNT = 12;

	logic clk;
	logic resetn;
	logic [7:0] paddle_target;
	logic plot;
	logic [7:0] pix_x;
	logic [6:0] pix_y;
	logic [2:0] pix_colour;

	// one run of back to back plots
	logic [7:0] px [CLEAR_PIXELS];
	logic [6:0] py [CLEAR_PIXELS];
	logic [2:0] pc [CLEAR_PIXELS];
	int burst_len;

	// stimulus table, paddle target and the column it should land on
	logic [7:0] target_tab [STIM_COUNT];
	logic [7:0] expect_tab [STIM_COUNT];
	int unsigned seed;

	// reference model
	int m_paddle;
	int m_ball_x;
	int m_ball_y;
	bit m_right;
	bit m_down;
	bit m_live [`BRICK_COUNT];

	string test_name;
	int test_errs;
	int tests_run;
	int tests_passed;
	int tests_failed;
	int stray_bursts;
	int ball_count;
	int cycles;

	brick_breaker_top #(
		.frame_ticks(FRAME_TICKS)
	) UUT (
		.clk(clk),
		.resetn(resetn),
		.paddle_target(paddle_target),
		.plot(plot),
		.x(pix_x),
		.y(pix_y),
		.colour(pix_colour)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// watchdog
	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// brick layout
	function automatic int brick_x(input int i);
		return `BRICK_W * (i % `BRICK_COLS);
	endfunction

	function automatic int brick_y(input int i);
		return `BRICK_PITCH_Y * (i / `BRICK_COLS);
	endfunction

	function automatic int brick_colour(input int i);
		return 1 + (i % 7);
	endfunction

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errs == 0)
		begin
			tests_passed++;
			$display("test %s passed", test_name);
		end
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, test_errs);
		end
	endtask

	task automatic check_count(input string what, input int expv, input int actv);
		if (actv != expv)
		begin
			$display("** Error %s %s: expected %0d, actual %0d", test_name, what, expv, actv);
			test_errs++;
		end
	endtask

	task automatic check_pixel(input int k, input int ex, input int ey, input int ec);
		if ({px[k], py[k], pc[k]} !== {8'(ex), 7'(ey), 3'(ec)})
		begin
			$display("** Error %s pixel %0d: expected (%0d,%0d,%0d), actual (%0d,%0d,%0d)",
				test_name, k, ex, ey, ec, px[k], py[k], pc[k]);
			test_errs++;
		end
	endtask

	// 16x4 block, row-major, starting at burst index base
	task automatic check_block(input int base, input int ox, input int oy, input int c);
		for (int k = 0; k < BLOCK_PIXELS; k++)
			if (base + k < burst_len)
				check_pixel(base + k, ox + k % 16, oy + k / 16, c);
	endtask

	task automatic check_ball(input int c);
		for (int k = 0; k < BALL_PIXELS; k++)
			if (k < burst_len)
				check_pixel(k, m_ball_x + (k & 1), m_ball_y + (k >> 1), c);
	endtask

	// waits for plot, then captures until it drops
	task automatic get_burst();
		burst_len = 0;
		@(negedge clk);
		while (plot !== 1'b1)
			@(negedge clk);
		while (plot === 1'b1)
		begin
			if (burst_len < CLEAR_PIXELS)
			begin
				px[burst_len] = pix_x;
				py[burst_len] = pix_y;
				pc[burst_len] = pix_colour;
			end
			burst_len++;
			@(negedge clk);
		end
	endtask

	// erase burst already captured
	task automatic paddle_update(input int i);
		start_test($sformatf("paddle_%0d", i));
		check_block(0, m_paddle, `PADDLE_Y, 0);
		get_burst();
		check_count("draw length", BLOCK_PIXELS, burst_len);
		m_paddle = expect_tab[i];
		check_block(0, m_paddle, `PADDLE_Y, 7);
		end_test();
	endtask

	task automatic ball_update();
		int hit;
		int ox;
		int oy;
		int old_x;
		bit cols;
		bit rows;
		ball_count++;
		start_test($sformatf("ball_%0d", ball_count));
		check_ball(0);

		// first live brick touching the ball wins
		hit = -1;
		for (int i = 0; i < `BRICK_COUNT && hit < 0; i++)
		begin
			if (m_live[i])
			begin
				ox = brick_x(i);
				oy = brick_y(i);
				cols = (m_ball_x >= ox) && (m_ball_x <= ox + 15);
				rows = (m_ball_y >= oy) && (m_ball_y <= oy + 3);
				if (cols && m_ball_y + 1 == oy)
				begin
					hit = i;
					m_down = 1'b0;
				end
				else if (cols && m_ball_y == oy + 4)
				begin
					hit = i;
					m_down = 1'b1;
				end
				else if (rows && m_ball_x + 1 == ox)
				begin
					hit = i;
					m_right = 1'b0;
				end
				else if (rows && m_ball_x == ox + 16)
				begin
					hit = i;
					m_right = 1'b1;
				end
			end
		end

		get_burst();
		if (hit >= 0)
		begin
			m_live[hit] = 1'b0;
			check_count("brick erase length", BLOCK_PIXELS, burst_len);
			check_block(0, brick_x(hit), brick_y(hit), 0);
			get_burst();
		end
		else if (burst_len == BLOCK_PIXELS)
		begin
			$display("%s: a brick at (%0d,%0d) was erased although no hit was expected",
				test_name, px[0], py[0]);
			test_errs++;
			get_burst();
		end

		old_x = m_ball_x; // paddle test uses the column before the move
		if (m_right)
		begin
			if (m_ball_x == `SCREEN_W - 2)
			begin
				m_ball_x = `SCREEN_W - 3;
				m_right = 1'b0;
			end
			else
				m_ball_x++;
		end
		else if (m_ball_x == 0)
		begin
			m_ball_x = 1;
			m_right = 1'b1;
		end
		else
			m_ball_x--;

		if (m_down)
		begin
			if (m_ball_y == `BALL_PADDLE_Y && old_x >= m_paddle && old_x <= m_paddle + 15)
			begin
				m_ball_y = `BALL_PADDLE_Y - 1;
				m_down = 1'b0;
			end
			else if (m_ball_y == `BALL_FLOOR_Y)
			begin
				m_ball_y = `BALL_FLOOR_Y - 1;
				m_down = 1'b0;
			end
			else
				m_ball_y++;
		end
		else if (m_ball_y == 0)
		begin
			m_ball_y = 1;
			m_down = 1'b1;
		end
		else
			m_ball_y--;

		check_count("draw length", BALL_PIXELS, burst_len);
		check_ball(4);
		end_test();
	endtask

	initial
	begin
		bit pad_done;
		resetn = 1'b0;
		tests_run = 0;
		tests_passed = 0;
		tests_failed = 0;
		stray_bursts = 0;
		ball_count = 0;

		// edge columns and the centre first, then pseudo random ones
		target_tab[0] = 8'd0;
		target_tab[1] = 8'd144;
		target_tab[2] = 8'd80;
		target_tab[3] = 8'd40;
		target_tab[4] = 8'd120;
		target_tab[5] = 8'd8;
		seed = 9;
		for (int i = 6; i < STIM_COUNT; i++)
		begin
			seed = lcg_next(seed);
			target_tab[i] = 8'((seed >> 16) % 145);
		end
		for (int i = 0; i < STIM_COUNT; i++)
			expect_tab[i] = target_tab[i]; // paddle lands on the target, no clamp
		paddle_target = target_tab[0];

		m_paddle = `PADDLE_RESET_X;
		m_ball_x = `BALL_RESET_X;
		m_ball_y = `BALL_RESET_Y;
		m_right = 1'b1;
		m_down = 1'b0;
		for (int i = 0; i < `BRICK_COUNT; i++)
			m_live[i] = 1'b1;

		start_test("reset");
		for (int i = 0; i < 3; i++)
		begin
			@(posedge clk);
			if (i == 2)
				resetn <= 1'b1;
			@(negedge clk);
			if (plot !== 1'b0)
			begin
				$display("** Error %s cycle %0d plot: expected 0, actual %b", test_name, i, plot);
				test_errs++;
			end
		end
		end_test();

		start_test("clear");
		get_burst();
		check_count("length", CLEAR_PIXELS, burst_len);
		for (int k = 0; k < CLEAR_PIXELS && k < burst_len; k++)
			check_pixel(k, k % `SCREEN_W, k / `SCREEN_W, 0);
		end_test();

		// bricks run straight into the first paddle draw
		start_test("bricks");
		get_burst();
		check_count("length", (`BRICK_COUNT + 1) * BLOCK_PIXELS, burst_len);
		for (int i = 0; i < `BRICK_COUNT; i++)
			check_block(i * BLOCK_PIXELS, brick_x(i), brick_y(i), brick_colour(i));
		end_test();

		start_test("paddle_init");
		check_block(`BRICK_COUNT * BLOCK_PIXELS, m_paddle, `PADDLE_Y, 7);
		end_test();

		for (int i = 0; i < STIM_COUNT; i++)
		begin
			pad_done = 1'b0;
			while (!pad_done)
			begin
				get_burst();
				if (burst_len == BLOCK_PIXELS)
				begin
					paddle_update(i);
					pad_done = 1'b1;
				end
				else if (burst_len == BALL_PIXELS)
					ball_update();
				else
				begin
					$display("unexpected run of %0d plots while waiting for an update", burst_len);
					stray_bursts++;
				end
			end
			if (i + 1 < STIM_COUNT)
			begin
				@(posedge clk);
				paddle_target <= target_tab[i + 1];
			end
		end

		$display("tests run %0d, passed %0d, failed %0d, stray plot runs %0d",
			tests_run, tests_passed, tests_failed, stray_bursts);
		if (tests_failed == 0 && stray_bursts == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* project.f */
+incdir+src
src/video_pkg.sv
src/game_pkg.sv
src/game_sequencer.sv
src/brick_table.sv
src/motion_unit.sv
src/pixel_painter.sv
src/brick_breaker_top.sv
dv/tb_brick_breaker.sv
